//--- Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/apb_if.sv
`timescale 1ns/1ps

interface apb_if;
  import bus_pkg::*;

  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // bus master side
  modport requester (
    output psel,
    output penable,
    output pwrite,
    output paddr,
    output pwdata,
    input  prdata,
    input  pready,
    input  pslverr
  );

  // memory side
  modport completer (
    input  psel,
    input  penable,
    input  pwrite,
    input  paddr,
    input  pwdata,
    output prdata,
    output pready,
    output pslverr
  );

endinterface

//--- source/bus_pkg.sv
package bus_pkg;

  // apb port widths
  localparam int APB_ADDR_BITS = 12;  // word index
  localparam int APB_DATA_BITS = 32;

  typedef logic [APB_ADDR_BITS-1:0] apb_addr_t;
  typedef logic [APB_DATA_BITS-1:0] apb_data_t;

  // completer phase tracking
  typedef enum logic {
    APB_IDLE   = 1'b0,
    APB_ACCESS = 1'b1
  } apb_state_e;

endpackage

//--- source/fetch_issue.sv
`timescale 1ns/1ps

module fetch_issue (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 pc_enable,
  input  fetch_pkg::pc_t                       candidate_pc,
  input  fetch_pkg::pc_t                       restore_pc,
  input  logic                                 restore_valid,
  output logic                                 restore_taken,
  output fetch_pkg::pc_t                       pc,
  output logic [fetch_pkg::IMEM_ADDR_BITS-1:0] read_addr,
  input  fetch_pkg::instr_t                    read_data,
  output fetch_pkg::instr_t                    instruction
);
  import fetch_pkg::*;

  pc_t pc_q;
  pc_t next_pc;

  // a pending restore overrides whatever the sequencer picked
  always_comb
  begin
    if (restore_valid)
      next_pc = restore_pc;
    else
      next_pc = candidate_pc;
  end

  // restore is consumed only on an enabled edge
  assign restore_taken = pc_enable && restore_valid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc_q <= RESET_VECTOR;
    end
    else if (pc_enable)
    begin
      pc_q <= next_pc;
    end
  end

  assign pc = pc_q;

  // memory indexed by the low pc bits
  assign read_addr = pc_q[IMEM_ADDR_BITS-1:0];

  // registered read, one cycle behind pc
  assign instruction = read_data;

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

  // program counter and instruction word widths
  localparam int PC_BITS    = 32;
  localparam int INSTR_BITS = 16;
  localparam int HALF_BITS  = PC_BITS / 2;

  typedef logic [PC_BITS-1:0]    pc_t;
  typedef logic [INSTR_BITS-1:0] instr_t;
  typedef logic [HALF_BITS-1:0]  half_t;  // one popped half of a pc

  // fixed fetch targets
  localparam pc_t RESET_VECTOR     = 32'h0000_0020;
  localparam pc_t INTERRUPT_VECTOR = 32'h0000_0000;

  // pc advances one word per instruction
  localparam pc_t PC_STEP = 32'd1;

  // instruction store, word addressed by the low pc bits
  localparam int IMEM_ADDR_BITS = 10;
  localparam int IMEM_DEPTH     = 1 << IMEM_ADDR_BITS;

  // next pc source
  typedef enum logic [1:0] {
    PC_NEXT      = 2'b00,
    PC_BRANCH    = 2'b01,
    PC_INTERRUPT = 2'b10,
    PC_RESET_VEC = 2'b11
  } pc_sel_e;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           pc_enable,
  input  fetch_pkg::pc_sel_e             pc_selection,
  input  fetch_pkg::pc_t                 branch_call_addr,
  input  logic                           pop_pc_low,
  input  logic                           pop_pc_high,
  input  fetch_pkg::half_t               pop_data,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [bus_pkg::APB_ADDR_BITS-1:0] paddr,
  input  logic [bus_pkg::APB_DATA_BITS-1:0] pwdata,
  output logic [bus_pkg::APB_DATA_BITS-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output fetch_pkg::pc_t                 pc,
  output fetch_pkg::instr_t              instruction
);
  import fetch_pkg::*;

  apb_if apb ();

  pc_t                       candidate_pc;
  pc_t                       restore_pc;
  logic                      restore_valid;
  logic                      restore_taken;
  logic [IMEM_ADDR_BITS-1:0] read_addr;
  instr_t                    read_data;

  // apb pins into the bundle
  assign apb.psel    = psel;
  assign apb.penable = penable;
  assign apb.pwrite  = pwrite;
  assign apb.paddr   = paddr;
  assign apb.pwdata  = pwdata;
  assign prdata      = apb.prdata;
  assign pready      = apb.pready;
  assign pslverr     = apb.pslverr;

  pc_sequencer u_pc_sequencer (
    .pc               (pc),
    .pc_selection     (pc_selection),
    .branch_call_addr (branch_call_addr),
    .candidate_pc     (candidate_pc)
  );

  return_assembler u_return_assembler (
    .clk           (clk),
    .reset         (reset),
    .pop_pc_low    (pop_pc_low),
    .pop_pc_high   (pop_pc_high),
    .pop_data      (pop_data),
    .restore_pc    (restore_pc),
    .restore_valid (restore_valid),
    .restore_taken (restore_taken)
  );

  fetch_issue u_fetch_issue (
    .clk           (clk),
    .reset         (reset),
    .pc_enable     (pc_enable),
    .candidate_pc  (candidate_pc),
    .restore_pc    (restore_pc),
    .restore_valid (restore_valid),
    .restore_taken (restore_taken),
    .pc            (pc),
    .read_addr     (read_addr),
    .read_data     (read_data),
    .instruction   (instruction)
  );

  instr_memory u_instr_memory (
    .clk       (clk),
    .reset     (reset),
    .bus       (apb.completer),
    .read_addr (read_addr),
    .read_data (read_data)
  );

endmodule

//--- source/instr_memory.sv
`timescale 1ns/1ps

module instr_memory (
  input  logic                                 clk,
  input  logic                                 reset,
  apb_if.completer                             bus,
  input  logic [fetch_pkg::IMEM_ADDR_BITS-1:0] read_addr,
  output fetch_pkg::instr_t                    read_data
);
  import fetch_pkg::*;
  import bus_pkg::*;

  instr_t     mem [IMEM_DEPTH];
  instr_t     read_q;
  apb_state_e state;
  logic       setup_cycle;
  logic       access_cycle;
  logic       out_of_range;
  logic       write_en;

  assign setup_cycle  = bus.psel && !bus.penable;
  assign access_cycle = (state == APB_ACCESS) && bus.psel && bus.penable;

  // word index must fall inside the store
  assign out_of_range = (bus.paddr >= APB_ADDR_BITS'(IMEM_DEPTH));
  assign write_en     = access_cycle && bus.pwrite && !out_of_range;

  // phase tracking
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= APB_IDLE;
    end
    else
    begin
      case (state)
        APB_IDLE:
        begin
          if (setup_cycle)
            state <= APB_ACCESS;
        end
        APB_ACCESS:
        begin
          if (access_cycle || !bus.psel)
            state <= APB_IDLE;  // transfer done or dropped
        end
        default:
        begin
          state <= APB_IDLE;
        end
      endcase
    end
  end

  // zero wait states, error only on bad writes
  assign bus.pready  = access_cycle;
  assign bus.pslverr = access_cycle && bus.pwrite && out_of_range;
  assign bus.prdata  = '0;  // program readback not supported

  // apb write port
  always_ff @(posedge clk)
  begin
    if (write_en)
      mem[bus.paddr[IMEM_ADDR_BITS-1:0]] <= bus.pwdata[INSTR_BITS-1:0];
  end

  // fetch read port, sees the old word on a same cycle write
  always_ff @(posedge clk)
  begin
    if (reset)
      read_q <= '0;
    else
      read_q <= mem[read_addr];
  end

  assign read_data = read_q;

endmodule

//--- source/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
  input  fetch_pkg::pc_t    pc,
  input  fetch_pkg::pc_sel_e pc_selection,
  input  fetch_pkg::pc_t    branch_call_addr,
  output fetch_pkg::pc_t    candidate_pc
);
  import fetch_pkg::*;

  pc_t incremented_pc;

  // sequential fetch, wraps at the top of the address space
  assign incremented_pc = pc + PC_STEP;

  always_comb
  begin
    case (pc_selection)
      PC_NEXT:
      begin
        candidate_pc = incremented_pc;
      end
      PC_BRANCH:
      begin
        candidate_pc = branch_call_addr;  // branch or call target
      end
      PC_INTERRUPT:
      begin
        candidate_pc = INTERRUPT_VECTOR;
      end
      PC_RESET_VEC:
      begin
        candidate_pc = RESET_VECTOR;
      end
      default:
      begin
        candidate_pc = incremented_pc;
      end
    endcase
  end

endmodule

//--- source/return_assembler.sv
`timescale 1ns/1ps

module return_assembler (
  input  logic              clk,
  input  logic              reset,
  input  logic              pop_pc_low,
  input  logic              pop_pc_high,
  input  fetch_pkg::half_t  pop_data,
  output fetch_pkg::pc_t    restore_pc,
  output logic              restore_valid,
  input  logic              restore_taken
);
  import fetch_pkg::*;

  half_t low_stage;     // low half waiting for its high half
  logic  low_seen;
  half_t restore_low;
  half_t restore_high;
  logic  valid_q;

  // control state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      low_seen <= 1'b0;
      valid_q  <= 1'b0;
    end
    else
    begin
      if (pop_pc_high)
        low_seen <= 1'b0;  // pair closed
      else if (pop_pc_low)
        low_seen <= 1'b1;

      // a new high pop wins over a same cycle accept
      if (pop_pc_high)
        valid_q <= 1'b1;
      else if (restore_taken)
        valid_q <= 1'b0;
    end
  end

  // staging register for the first popped half
  always_ff @(posedge clk)
  begin
    if (pop_pc_low)
      low_stage <= pop_data;
  end

  // restore target, updated only when the high half lands
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      restore_low  <= '0;
      restore_high <= '0;
    end
    else if (pop_pc_high)
    begin
      restore_high <= pop_data;
      if (low_seen)
        restore_low <= low_stage;  // otherwise previous low half stays
    end
  end

  assign restore_pc    = {restore_high, restore_low};
  assign restore_valid = valid_q;

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int PROGRAM_WORDS   = 64;
  localparam int TEST_CYCLES     = RESET_CYCLES + PROGRAM_WORDS * 3 + 160;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 300;  // margin on top of the tests

  // expected vectors and memory size, taken from the fetch rules
  localparam logic [31:0] BOOT_PC   = 32'h0000_0020;
  localparam logic [31:0] VECTOR_PC = 32'h0000_0000;
  localparam logic [11:0] MEM_WORDS = 12'd1024;

  logic        clk;
  logic        reset;
  logic        pc_enable;
  pc_sel_e     pc_selection;
  logic [31:0] branch_call_addr;
  logic        pop_pc_low;
  logic        pop_pc_high;
  logic [15:0] pop_data;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] pc;
  logic [15:0] instruction;

  string       test_name;
  logic [31:0] rng_state;

  // reference model state
  logic [15:0] shadow [1024];
  logic        written [1024];
  logic [31:0] model_pc;
  logic [15:0] model_instr;
  logic        instr_known;      // shadow word at the fetched address was loaded
  logic [15:0] low_stage;
  logic        low_seen;
  logic [15:0] restore_lo;
  logic [15:0] restore_hi;
  logic        restore_pending;

  fetch_top DUT (
    .clk              (clk),
    .reset            (reset),
    .pc_enable        (pc_enable),
    .pc_selection     (pc_selection),
    .branch_call_addr (branch_call_addr),
    .pop_pc_low       (pop_pc_low),
    .pop_pc_high      (pop_pc_high),
    .pop_data         (pop_data),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .pc               (pc),
    .instruction      (instruction)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_on_error($sformatf("[FAIL] %s: %s expected %h actual %h",
                            test_name, what, expected, actual));
  endtask

  // pc, fetch, call stack and shadow memory follow the stage rules
  always @(posedge clk)
  begin
    if (reset)
    begin
      model_pc        <= BOOT_PC;
      model_instr     <= '0;
      instr_known     <= 1'b1;
      low_seen        <= 1'b0;
      restore_lo      <= '0;
      restore_hi      <= '0;
      restore_pending <= 1'b0;
      for (int i = 0; i < 1024; i++)
        written[i] <= 1'b0;
    end
    else
    begin
      model_instr <= shadow[model_pc[9:0]];  // old word on a same cycle write
      instr_known <= written[model_pc[9:0]];
      if (pc_enable)
      begin
        if (restore_pending)
          model_pc <= {restore_hi, restore_lo};
        else if (pc_selection == PC_BRANCH)
          model_pc <= branch_call_addr;
        else if (pc_selection == PC_INTERRUPT)
          model_pc <= VECTOR_PC;
        else if (pc_selection == PC_RESET_VEC)
          model_pc <= BOOT_PC;
        else
          model_pc <= model_pc + 32'd1;
      end
      if (pop_pc_high)
      begin
        restore_hi      <= pop_data;
        restore_pending <= 1'b1;
        low_seen        <= 1'b0;
        if (low_seen)
          restore_lo <= low_stage;
      end
      else
      begin
        if (pc_enable)
          restore_pending <= 1'b0;
        if (pop_pc_low)
        begin
          low_stage <= pop_data;
          low_seen  <= 1'b1;
        end
      end
      if (psel && penable && pwrite && paddr < MEM_WORDS)
      begin
        shadow[paddr[9:0]]  <= pwdata[15:0];
        written[paddr[9:0]] <= 1'b1;
      end
    end
  end

  a_pc: assert property (@(posedge clk) disable iff (reset) pc == model_pc)
    else report_mismatch("pc", $sampled(model_pc), $sampled(pc));

  a_instr: assert property (@(posedge clk) disable iff (reset)
                            !instr_known || instruction == model_instr)
    else report_mismatch("instruction", {16'b0, $sampled(model_instr)},
                         {16'b0, $sampled(instruction)});

  a_bus_quiet: assert property (@(posedge clk) disable iff (reset)
                                !(psel && penable) |-> !pready && !pslverr)
    else report_mismatch("idle pready,pslverr", 32'd0,
                         {30'b0, $sampled(pready), $sampled(pslverr)});

  a_ready: assert property (@(posedge clk) disable iff (reset) psel && penable |-> pready)
    else report_mismatch("access pready", 32'd1, {31'b0, $sampled(pready)});

  a_slverr: assert property (@(posedge clk) disable iff (reset)
                             psel && penable && pwrite |-> pslverr == (paddr >= MEM_WORDS))
    else report_mismatch("pslverr", {31'b0, $sampled(paddr) >= MEM_WORDS},
                         {31'b0, $sampled(pslverr)});

  a_prdata: assert property (@(posedge clk) disable iff (reset)
                             psel && penable && !pwrite |-> prdata == 32'd0)
    else report_mismatch("prdata", 32'd0, $sampled(prdata));

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_cycles(input int count);
    repeat (count) next_cycle();
  endtask

  task automatic apb_transfer(input logic is_write, input logic [11:0] addr,
                              input logic [31:0] data);
    int waits;
    waits   = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = is_write;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    #1;
    while (!pready && waits < 8)
    begin
      next_cycle();
      waits++;
    end
    if (!pready)
      stop_on_error("APB transfer never saw pready from the instruction memory");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic select_once(input pc_sel_e sel, input logic [31:0] target);
    pc_selection     = sel;
    branch_call_addr = target;
    next_cycle();
    pc_selection     = PC_NEXT;
  endtask

  // low half first, then the high half
  task automatic pop_return(input logic [31:0] target);
    pop_pc_low  = 1'b1;
    pop_data    = target[15:0];
    next_cycle();
    pop_pc_low  = 1'b0;
    pop_pc_high = 1'b1;
    pop_data    = target[31:16];
    next_cycle();
    pop_pc_high = 1'b0;
    pop_data    = '0;
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_on_error("watchdog expired before the tests finished, the DUT or a test hung");
  end

  initial
  begin
    clk              = 1'b0;
    reset            = 1'b1;
    pc_enable        = 1'b0;
    pc_selection     = PC_NEXT;
    branch_call_addr = '0;
    pop_pc_low       = 1'b0;
    pop_pc_high      = 1'b0;
    pop_data         = '0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    rng_state        = 32'd50;
    test_name        = "reset_state";
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    run_cycles(3);

    test_name = "program_load";  // pc frozen while the program goes in
    for (int i = 0; i < PROGRAM_WORDS; i++)
    begin
      rng_state = xorshift32(rng_state);
      apb_transfer(1'b1, 12'(i), rng_state);
    end
    run_cycles(2);

    test_name = "sequential";
    pc_enable = 1'b1;
    run_cycles(20);
    test_name = "branch";
    select_once(PC_BRANCH, 32'h0000_0005);
    run_cycles(6);
    test_name = "interrupt";
    select_once(PC_INTERRUPT, 32'h0000_0031);
    run_cycles(4);
    test_name = "reset_vector";
    select_once(PC_RESET_VEC, 32'h0000_0031);
    run_cycles(4);

    test_name = "hold";
    pc_enable = 1'b0;
    run_cycles(6);
    pc_enable = 1'b1;

    test_name = "restore";
    pop_return(32'h0000_0010);
    run_cycles(3);
    test_name = "restore_stalled";
    pc_enable = 1'b0;
    pop_return(32'h0001_0030);
    run_cycles(3);
    pc_enable = 1'b1;
    run_cycles(3);
    test_name = "restore_vs_branch";
    pop_return(32'h0000_0008);
    select_once(PC_BRANCH, 32'h0000_003a);
    run_cycles(3);

    test_name = "apb_write";
    apb_transfer(1'b1, 12'h007, 32'h1234_beef);
    select_once(PC_BRANCH, 32'h0000_0007);
    run_cycles(3);
    test_name = "apb_read";
    apb_transfer(1'b0, 12'h007, 32'h0000_0000);  // reads come back as zero
    run_cycles(2);
    test_name = "apb_error";
    apb_transfer(1'b1, 12'h400, 32'h0000_dead);  // would alias word 0 if stored
    apb_transfer(1'b1, 12'hfff, 32'h0000_cafe);
    select_once(PC_BRANCH, 32'h0000_0000);
    run_cycles(3);
    test_name = "same_cycle_write";
    select_once(PC_BRANCH, 32'h0000_0009);
    pc_enable = 1'b0;
    apb_transfer(1'b1, 12'h009, 32'h0000_5a5a);
    run_cycles(3);
    pc_enable = 1'b1;
    run_cycles(2);

    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog.f
source/fetch_pkg.sv
source/bus_pkg.sv
source/apb_if.sv
source/pc_sequencer.sv
source/return_assembler.sv
source/instr_memory.sv
source/fetch_issue.sv
source/fetch_top.sv
verification/fetch_tb.sv
